// ==== frac_ps_golden.txt ====
# name enable dir num denom cycles done_delay lock_at lock_len exp_requests exp_position exp_overrun
# lock_len 0 keeps locked high, lock window counted in enabled cycles from the start of the run
rate        1 1  3   16  160  3   0    0  30   30 0
direction   1 0  3   16  160  3   0    0  30  -30 0
lock_gate   1 1  3   16  160  3  40   50  30   30 0
overrun     1 1 15   16  400 40   0    0 375  265 1
disable     0 1  3   16  160  3   0    0   0    0 0
rate_fast   1 1  1    2  100  1   0    0  50   50 0
rate_slow   1 1  7 1000 2000  5   0    0  14   14 0
dec_fast    1 0  5    8   64  2   0    0  40  -40 0
lock_long   1 1  1    4  200  2  10  150  50   50 0

// ==== list.f ====
+incdir+.
frac_ps_pkg.sv
ps_rate_accum.sv
ps_pending_counter.sv
ps_seq_fsm.sv
ps_position_tracker.sv
frac_ps_top.sv
frac_ps_assert.sv
tb_frac_ps.sv

// ==== Bender.yml ====
package:
  name: frac_ps

export_include_dirs:
  - .

sources:
  # controller RTL in compile order
  - frac_ps_pkg.sv
  - ps_rate_accum.sv
  - ps_pending_counter.sv
  - ps_seq_fsm.sv
  - ps_position_tracker.sv
  - frac_ps_top.sv
  # testbench and bound checks
  - target: test
    files:
      - frac_ps_assert.sv
      - tb_frac_ps.sv

// ==== tb_frac_ps.sv ====
// testbench for the fractional phase-shift controller driven by golden test vectors

`timescale 1ns/1ps
`default_nettype none

`include "frac_ps_defs.svh"

module tb_frac_ps
    import frac_ps_pkg::*;
();

    localparam int MAX_TESTS = 16;
    localparam int RESET_CYC = 8;
    localparam int CLK_HALF  = 50;
    localparam int DRIVE_DLY = 10;
    localparam int PEND_MAX  = (1 << `FPS_PEND_W) - 1;

    logic       output_clk;
    logic       rst_n;
    ps_cfg_t    cfg;
    logic       locked;
    logic       psdone;
    logic       psen;
    logic       psincdec;
    ps_status_t status;

    // one entry per golden line
    string t_name     [MAX_TESTS];
    int    t_enable   [MAX_TESTS];
    int    t_dir      [MAX_TESTS];
    int    t_num      [MAX_TESTS];
    int    t_denom    [MAX_TESTS];
    int    t_cycles   [MAX_TESTS];
    int    t_delay    [MAX_TESTS];
    int    t_lock_at  [MAX_TESTS];
    int    t_lock_len [MAX_TESTS];
    int    t_req      [MAX_TESTS];
    int    t_pos      [MAX_TESTS];
    int    t_ovr      [MAX_TESTS];
    int    num_tests;

    int   done_delay;
    int   done_cnt;
    int   cycle_count;
    int   cycle_limit;
    int   req_count;
    int   psen_count;
    int   pend_peak;
    bit   lock_violation;
    logic locked_prev = 1'b1;
    int   check_errors;
    int   tests_failed;

    frac_ps_top i_frac_ps_top (
        .output_clk (output_clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .locked     (locked),
        .psdone     (psdone),
        .psen       (psen),
        .psincdec   (psincdec),
        .status     (status)
    );

    initial begin
        output_clk = 1'b0;
        forever begin
            #(CLK_HALF) output_clk = ~output_clk;
        end
    end

    // clock manager port model answering each psen with psdone after a fixed delay
    initial begin
        done_cnt = 0;
        psdone   = 1'b0;
        forever begin
            @(posedge output_clk);
            #(DRIVE_DLY);
            psdone = 1'b0;
            if (done_cnt > 0) begin
                done_cnt = done_cnt - 1;
                if (done_cnt == 0) begin
                    psdone = 1'b1;
                end
            end
            if (psen) begin
                done_cnt = done_delay;
            end
        end
    end

    // mid-cycle sampling of requests, pulses, pending level and lock gating
    always @(negedge output_clk) begin
        if (rst_n) begin
            if (i_frac_ps_top.step_req) begin
                req_count++;
            end
            if (status.pending > pend_peak) begin
                pend_peak = status.pending;
            end
            if (psen) begin
                psen_count++;
                if (!locked_prev) begin
                    lock_violation = 1'b1;
                end
            end
        end
        locked_prev = locked;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge output_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic read_golden(input int fd);
        string line;
        string name;
        int    got;
        int    v_en, v_dir, v_num, v_den, v_cyc, v_dly;
        int    v_lat, v_llen, v_req, v_pos, v_ovr;
        num_tests = 0;
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            got  = $fgets(line, fd);
            // skip blank and comment lines
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name, v_en,
                              v_dir, v_num, v_den, v_cyc, v_dly, v_lat, v_llen, v_req,
                              v_pos, v_ovr);
                if (got == 12) begin
                    t_name[num_tests]     = name;
                    t_enable[num_tests]   = v_en;
                    t_dir[num_tests]      = v_dir;
                    t_num[num_tests]      = v_num;
                    t_denom[num_tests]    = v_den;
                    t_cycles[num_tests]   = v_cyc;
                    t_delay[num_tests]    = v_dly;
                    t_lock_at[num_tests]  = v_lat;
                    t_lock_len[num_tests] = v_llen;
                    t_req[num_tests]      = v_req;
                    t_pos[num_tests]      = v_pos;
                    t_ovr[num_tests]      = v_ovr;
                    num_tests++;
                end
            end
        end
    endtask

    task automatic apply_reset();
        rst_n  = 1'b0;
        cfg    = '0;
        locked = 1'b1;
        repeat (RESET_CYC) @(posedge output_clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
    endtask

    // drained once nothing is pending and no step is in flight
    task automatic wait_idle();
        bit idle;
        idle = 1'b0;
        repeat (2) @(posedge output_clk);
        while (!idle) begin
            @(negedge output_clk);
            idle = (status.pending == '0) && !psen && !psdone && (done_cnt == 0);
        end
        @(posedge output_clk);
        #(DRIVE_DLY);
    endtask

    task automatic check_value(input string test, input string what, input int expected,
                               input int actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test, what, expected, actual);
            check_errors++;
        end
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        int act_pos;
        int exp_steps;
        int c;
        errors_before = check_errors;
        apply_reset();
        done_delay     = t_delay[idx];
        req_count      = 0;
        psen_count     = 0;
        pend_peak      = 0;
        lock_violation = 1'b0;
        cfg.dir    = t_dir[idx][0];
        cfg.num    = t_num[idx][`FPS_FRAC_W-1:0];
        cfg.denom  = t_denom[idx][`FPS_FRAC_W-1:0];
        cfg.enable = t_enable[idx][0];
        for (c = 0; c < t_cycles[idx]; c++) begin
            if (t_lock_len[idx] > 0 && c == t_lock_at[idx]) begin
                locked = 1'b0;
            end
            if (c == t_lock_at[idx] + t_lock_len[idx]) begin
                locked = 1'b1;
            end
            @(posedge output_clk);
            #(DRIVE_DLY);
        end
        // dir stays so the drained steps keep their sign
        cfg.enable = 1'b0;
        locked     = 1'b1;
        wait_idle();
        act_pos   = $signed(status.position);
        exp_steps = (t_pos[idx] < 0) ? -t_pos[idx] : t_pos[idx];
        check_value(t_name[idx], "requests", t_req[idx], req_count);
        check_value(t_name[idx], "position", t_pos[idx], act_pos);
        check_value(t_name[idx], "steps issued", exp_steps, psen_count);
        check_value(t_name[idx], "overrun", t_ovr[idx], status.overrun);
        check_value(t_name[idx], "pending saturated", t_ovr[idx],
                    (pend_peak == PEND_MAX) ? 1 : 0);
        check_value(t_name[idx], "psincdec", t_dir[idx], psincdec);
        assert (!lock_violation) else begin
            $display("%s: psen was issued while locked was low", t_name[idx]);
            check_errors++;
        end
        if (check_errors == errors_before) begin
            $display("test %s passed", t_name[idx]);
        end else begin
            $display("test %s failed with %0d errors", t_name[idx],
                     check_errors - errors_before);
            tests_failed++;
        end
    endtask

    initial begin : main
        int fd;
        int i;
        int assert_fails;
        rst_n        = 1'b0;
        cfg          = '0;
        locked       = 1'b1;
        done_delay   = 1;
        cycle_count  = 0;
        cycle_limit  = 0;
        check_errors = 0;
        tests_failed = 0;
        fd = $fopen("frac_ps_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open frac_ps_golden.txt");
            $display("Simulation FAILED");
        end else begin
            read_golden(fd);
            $fclose(fd);
            // reset, run, lock outage and every step round trip plus slack
            cycle_limit = 200;
            for (i = 0; i < num_tests; i++) begin
                cycle_limit += RESET_CYC + t_cycles[i] + t_lock_len[i] +
                               (t_delay[i] + 2) * t_req[i] + 32;
            end
            for (i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            assert_fails = i_frac_ps_top.i_frac_ps_assert.fail_count;
            $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                     num_tests, num_tests - tests_failed, tests_failed, check_errors,
                     assert_fails);
            if (num_tests > 0 && check_errors == 0 && assert_fails == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== frac_ps_assert.sv ====
// protocol checks on the psen/psdone port and the rate configuration, bound into the top

`timescale 1ns/1ps
`default_nettype none

module frac_ps_assert
    import frac_ps_pkg::*;
(
    input wire logic    output_clk,
    input wire logic    rst_n,
    input wire ps_cfg_t cfg,
    input wire logic    psen,
    input wire logic    psdone
);

    int   fail_count = 0;
    logic in_flight;

    // set by the psen cycle, cleared by the psdone cycle
    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (psen && !psdone) begin
            in_flight <= 1'b1;
        end else if (psdone) begin
            in_flight <= 1'b0;
        end
    end

    a_single_pulse: assert property (@(posedge output_clk) disable iff (!rst_n)
        psen |=> !psen)
        else begin
            $error("psen high on two consecutive cycles");
            fail_count++;
        end

    a_one_in_flight: assert property (@(posedge output_clk) disable iff (!rst_n)
        in_flight |-> !psen)
        else begin
            $error("psen issued before psdone of the previous step");
            fail_count++;
        end

    // also rules out a zero denom
    a_cfg_valid: assert property (@(posedge output_clk) disable iff (!rst_n)
        cfg.enable |-> (cfg.num < cfg.denom))
        else begin
            $error("num not below denom while enabled");
            fail_count++;
        end

endmodule

bind frac_ps_top frac_ps_assert i_frac_ps_assert (
    .output_clk (output_clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .psen       (psen),
    .psdone     (psdone)
);

`default_nettype wire

// ==== frac_ps_top.sv ====
// fractional fine phase-shift controller driving a clock manager's dynamic phase-shift port

`timescale 1ns/1ps
`default_nettype none

module frac_ps_top
    import frac_ps_pkg::*;
(
    input  wire logic    output_clk,
    input  wire logic    rst_n,
    input  wire ps_cfg_t cfg,
    input  wire logic    locked,
    input  wire logic    psdone,
    output logic         psen,
    output logic         psincdec,
    output ps_status_t   status
);

    logic  step_req;
    logic  pending_nz;
    logic  overrun;
    pend_t pending;
    pos_t  position;

    // rate to request strobes
    ps_rate_accum i_rate_accum (
        .output_clk (output_clk),
        .rst_n      (rst_n),
        .enable     (cfg.enable),
        .num        (cfg.num),
        .denom      (cfg.denom),
        .step_req   (step_req)
    );

    // absorbs requests while a step is in flight or lock is lost
    ps_pending_counter i_pending_counter (
        .output_clk (output_clk),
        .rst_n      (rst_n),
        .step_req   (step_req),
        .issue      (psen),
        .pending    (pending),
        .pending_nz (pending_nz),
        .overrun    (overrun)
    );

    ps_seq_fsm i_seq_fsm (
        .output_clk (output_clk),
        .rst_n      (rst_n),
        .locked     (locked),
        .pending_nz (pending_nz),
        .psdone     (psdone),
        .psen       (psen)
    );

    ps_position_tracker i_position_tracker (
        .output_clk (output_clk),
        .rst_n      (rst_n),
        .psdone     (psdone),
        .dir        (cfg.dir),
        .position   (position)
    );

    // 1 selects increment on the port
    assign psincdec = cfg.dir;

    assign status.position = position;
    assign status.pending  = pending;
    assign status.overrun  = overrun;

endmodule

`default_nettype wire

// ==== ps_position_tracker.sv ====
// signed running count of completed fine phase-shift taps

`timescale 1ns/1ps
`default_nettype none

module ps_position_tracker
    import frac_ps_pkg::*;
(
    input  wire logic output_clk,
    input  wire logic rst_n,
    input  wire logic psdone,
    input  wire logic dir,
    output pos_t      position
);

    pos_t position_next;

    // one tap per completed step, wraps at the width
    always_comb begin
        position_next = position;
        if (psdone) begin
            if (dir) begin
                position_next = position + pos_t'(1);
            end else begin
                position_next = position - pos_t'(1);
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            position <= '0;
        end else begin
            position <= position_next;
        end
    end

endmodule

`default_nettype wire

// ==== ps_seq_fsm.sv ====
// step sequencer issuing single psen pulses and waiting for psdone, gated by lock

`timescale 1ns/1ps
`default_nettype none

module ps_seq_fsm
    import frac_ps_pkg::*;
(
    input  wire logic output_clk,
    input  wire logic rst_n,
    input  wire logic locked,
    input  wire logic pending_nz,
    input  wire logic psdone,
    output logic      psen
);

    seq_state_e state;
    seq_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                // only start a step while the clock manager is locked
                if (locked && pending_nz) begin
                    state_next = SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: begin
                // a port answering within the pulse cycle is still honoured
                if (psdone) begin
                    state_next = SEQ_IDLE;
                end else begin
                    state_next = SEQ_WAIT_DONE;
                end
            end
            SEQ_WAIT_DONE: begin
                // a started step always completes, even if lock drops
                if (psdone) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // one cycle pulse per step
    assign psen = (state == SEQ_ISSUE);

endmodule

`default_nettype wire

// ==== ps_pending_counter.sv ====
// saturating count of requested but not yet issued phase steps, sticky overrun

`timescale 1ns/1ps
`default_nettype none

module ps_pending_counter
    import frac_ps_pkg::*;
(
    input  wire logic output_clk,
    input  wire logic rst_n,
    input  wire logic step_req,
    input  wire logic issue,
    output pend_t     pending,
    output logic      pending_nz,
    output logic      overrun
);

    assign pending_nz = |pending;

    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            pending <= '0;
            overrun <= 1'b0;
        end else begin
            case ({step_req, issue})
                2'b10: begin
                    // full, the request is lost
                    if (pending == pend_t'('1)) begin
                        overrun <= 1'b1;
                    end else begin
                        pending <= pending + 1'b1;
                    end
                end
                2'b01: begin
                    if (pending_nz) begin
                        pending <= pending - 1'b1;
                    end
                end
                // request and issue together cancel out
                default: begin
                    pending <= pending;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== ps_rate_accum.sv ====
// fractional phase accumulator spreading num step requests over denom cycles

`timescale 1ns/1ps
`default_nettype none

`include "frac_ps_defs.svh"

module ps_rate_accum (
    input  wire logic                   output_clk,
    input  wire logic                   rst_n,
    input  wire logic                   enable,
    input  wire logic [`FPS_FRAC_W-1:0] num,
    input  wire logic [`FPS_FRAC_W-1:0] denom,
    output logic                        step_req
);

    logic [`FPS_FRAC_W-1:0] acc;

    // one extra bit so acc + num cannot wrap
    logic [`FPS_FRAC_W:0] sum;
    logic [`FPS_FRAC_W:0] rem;
    logic                 wrap;

    assign sum  = {1'b0, acc} + {1'b0, num};
    assign rem  = sum - {1'b0, denom};
    assign wrap = (sum >= {1'b0, denom});

    // bresenham style spread, the residue stays below denom
    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            acc      <= '0;
            step_req <= 1'b0;
        end else if (!enable) begin
            // restart from zero so the next run counts floor(n*num/denom)
            acc      <= '0;
            step_req <= 1'b0;
        end else if (wrap) begin
            acc      <= rem[`FPS_FRAC_W-1:0];
            step_req <= 1'b1;
        end else begin
            acc      <= sum[`FPS_FRAC_W-1:0];
            step_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== frac_ps_pkg.sv ====
// shared types for the fractional phase-shift controller configuration and status

`default_nettype none

`include "frac_ps_defs.svh"

package frac_ps_pkg;

    typedef logic [`FPS_PEND_W-1:0] pend_t;
    typedef logic signed [`FPS_POS_W-1:0] pos_t;

    // step sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT_DONE
    } seq_state_e;

    // software rate setting, num taps every denom cycles
    // valid only with denom nonzero and num below denom
    typedef struct packed {
        logic                   enable;
        logic                   dir;     // 1 shifts forward
        logic [`FPS_FRAC_W-1:0] num;
        logic [`FPS_FRAC_W-1:0] denom;
    } ps_cfg_t;

    typedef struct packed {
        pos_t  position;
        pend_t pending;
        logic  overrun;
    } ps_status_t;

endpackage

`default_nettype wire

// ==== frac_ps_defs.svh ====
// fine phase-shift controller widths for the fraction, pending count and position

`ifndef FRAC_PS_DEFS_SVH
`define FRAC_PS_DEFS_SVH

// num, denom and the phase accumulator
`define FPS_FRAC_W 16

// outstanding step requests, saturates at 255
`define FPS_PEND_W 8

// signed net tap count, wraps at the width
`define FPS_POS_W 24

`endif
